//--- include/ntt_defs.svh
// Shared defines for the NTT core head partition
// Operand width, modulus, transform size and stage count
// Pipeline latencies of the arithmetic blocks
// Key FIFO depth and batch id width

`ifndef NTT_DEFS_SVH
`define NTT_DEFS_SVH

// ----------------------------------------------------------
// Arithmetic
// ----------------------------------------------------------
// Coefficient width in bits
`define NTT_OP_W 13
// Prime modulus, 7681 = 15 * 2**9 + 1
`define NTT_MOD 7681

// ----------------------------------------------------------
// Transform shape
// ----------------------------------------------------------
`define NTT_N 8
// log2 of NTT_N
`define NTT_S 3

// ----------------------------------------------------------
// Latencies and sizes
// ----------------------------------------------------------
`define NTT_MULT_LAT 2
`define NTT_BFLY_LAT 3
`define NTT_PP_FIFO_DEPTH 4
`define NTT_ID_W 4

`endif

//--- src/ntt_core_pkg.sv
// Type definitions of the NTT core head partition
// Coefficient, polynomial block, twiddle powers, batch id and raw product

`default_nettype none

`include "ntt_defs.svh"

package ntt_core_pkg;

  // One residue modulo NTT_MOD
  typedef logic [`NTT_OP_W-1:0] coef_t;

  // One polynomial block, index 0 in the low bits
  typedef coef_t [`NTT_N-1:0] block_t;

  // Omega to the powers 0 .. N/2-1
  // Quasi static, set once before traffic
  typedef coef_t [`NTT_N/2-1:0] twd_pow_t;

  // Batch identifier carried in the sideband
  typedef logic [`NTT_ID_W-1:0] batch_id_t;

  // Full product of two residues before reduction
  typedef logic [2*`NTT_OP_W-1:0] prod_t;

endpackage

`default_nettype wire

//--- src/ntt_mod_mult.sv
// Pipelined modular multiplier
// First cycle registers the raw product
// Second cycle registers the remainder by the modulus

`timescale 1ns/1ns
`default_nettype none

`include "ntt_defs.svh"

module ntt_mod_mult
  import ntt_core_pkg::*;
(
  input  wire   clk,
  input  wire   reset,
  input  wire   coef_t a,
  input  wire   coef_t b,
  output coef_t z
);

  localparam prod_t MOD_P = prod_t'(`NTT_MOD);

  prod_t prod_q;
  prod_t rem;

  // Plain remainder, no special-form reduction
  always_comb begin
    rem = prod_q % MOD_P;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_q <= '0;
      z      <= '0;
    end else begin
      prod_q <= a * b;
      // Remainder is below NTT_MOD so the low bits hold it all
      z      <= rem[`NTT_OP_W-1:0];
    end
  end

endmodule

`default_nettype wire

//--- src/ntt_bfly.sv
// Radix-2 decimation-in-time butterfly
// Twiddle multiply on b, then modular add and subtract with a
// Outputs a + w*b and a - w*b, three cycles after the inputs

`timescale 1ns/1ns
`default_nettype none

`include "ntt_defs.svh"

module ntt_bfly
  import ntt_core_pkg::*;
(
  input  wire   clk,
  input  wire   reset,
  input  wire   coef_t a,
  input  wire   coef_t b,
  input  wire   coef_t w,
  output coef_t sum,
  output coef_t diff
);

  // One extra bit for the unreduced add
  localparam logic [`NTT_OP_W:0] MOD_EXT = `NTT_MOD;

  coef_t a_d1;
  coef_t a_d2;
  coef_t wb;
  logic [`NTT_OP_W:0] sum_raw;
  logic [`NTT_OP_W:0] sum_red;
  logic [`NTT_OP_W:0] diff_raw;
  logic [`NTT_OP_W:0] diff_red;

  // w*b, two cycles
  ntt_mod_mult u_mult (
    .clk   (clk),
    .reset (reset),
    .a     (w),
    .b     (b),
    .z     (wb)
  );

  // ----------------------------------------------------------
  // Modular add and subtract
  // ----------------------------------------------------------
  always_comb begin
    sum_raw  = {1'b0, a_d2} + {1'b0, wb};
    sum_red  = (sum_raw >= MOD_EXT) ? sum_raw - MOD_EXT : sum_raw;
    // Bias by the modulus so the difference never goes negative
    diff_raw = {1'b0, a_d2} + MOD_EXT - {1'b0, wb};
    diff_red = (diff_raw >= MOD_EXT) ? diff_raw - MOD_EXT : diff_raw;
  end

  // Align a with the multiplier output, then register the results
  always_ff @(posedge clk) begin
    a_d1 <= a;
    a_d2 <= a_d1;
    sum  <= sum_red[`NTT_OP_W-1:0];
    diff <= diff_red[`NTT_OP_W-1:0];
  end

endmodule

`default_nettype wire

//--- src/ntt_stage.sv
// One unfolded radix-2 transform stage
// Row of N/2 butterflies with the stage position wiring
// Twiddle selection from the omega powers
// Sideband and avail delay matching the butterfly latency

`timescale 1ns/1ns
`default_nettype none

`include "ntt_defs.svh"

module ntt_stage
  import ntt_core_pkg::*;
#(
  parameter int STAGE_ID = 0
) (
  input  wire       clk,
  input  wire       reset,
  input  wire       block_t prev_data,
  input  wire       prev_avail,
  input  wire       prev_sob,
  input  wire       prev_eob,
  input  wire       batch_id_t prev_pbs_id,
  input  wire       twd_pow_t twd_pow,
  output block_t    next_data,
  output logic      next_avail,
  output logic      next_sob,
  output logic      next_eob,
  output batch_id_t next_pbs_id
);

  localparam int LAT  = `NTT_BFLY_LAT;
  // Distance between the two inputs of a butterfly
  localparam int HALF = 1 << STAGE_ID;

  logic [LAT-1:0] avail_sr;
  logic [LAT-1:0] sob_sr;
  logic [LAT-1:0] eob_sr;
  batch_id_t      id_sr [LAT];

  // ----------------------------------------------------------
  // Butterfly row
  // ----------------------------------------------------------
  for (genvar b = 0; b < `NTT_N/2; b++) begin : gen_bfly
    // Group of width 2*HALF, offset j inside it
    localparam int POS_A   = (b / HALF) * 2 * HALF + (b % HALF);
    localparam int POS_B   = POS_A + HALF;
    // Exponent j * (N/2) / HALF
    localparam int TWD_IDX = (b % HALF) * ((`NTT_N / 2) / HALF);

    ntt_bfly u_bfly (
      .clk   (clk),
      .reset (reset),
      .a     (prev_data[POS_A]),
      .b     (prev_data[POS_B]),
      .w     (twd_pow[TWD_IDX]),
      .sum   (next_data[POS_A]),
      .diff  (next_data[POS_B])
    );
  end

  // ----------------------------------------------------------
  // Sideband delay
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      avail_sr <= '0;
    end else begin
      avail_sr <= {avail_sr[LAT-2:0], prev_avail};
    end
  end

  // Control fields only matter where avail is set
  always_ff @(posedge clk) begin
    sob_sr   <= {sob_sr[LAT-2:0], prev_sob};
    eob_sr   <= {eob_sr[LAT-2:0], prev_eob};
    id_sr[0] <= prev_pbs_id;
    for (int i = 1; i < LAT; i++) begin
      id_sr[i] <= id_sr[i-1];
    end
  end

  assign next_avail  = avail_sr[LAT-1];
  assign next_sob    = sob_sr[LAT-1];
  assign next_eob    = eob_sr[LAT-1];
  assign next_pbs_id = id_sr[LAT-1];

endmodule

`default_nettype wire

//--- src/ntt_seq.sv
// Input sequencer of the NTT head
// Joins the data and control streams under valid/ready
// Registers the accepted beat in bit-reversed coefficient order
// One avail pulse per accepted beat

`timescale 1ns/1ns
`default_nettype none

`include "ntt_defs.svh"

module ntt_seq
  import ntt_core_pkg::*;
(
  input  wire       clk,
  input  wire       reset,
  // Data stream
  input  wire       block_t in_data,
  input  wire       in_data_vld,
  output logic      in_data_rdy,
  // Control stream
  input  wire       in_ctrl_vld,
  output logic      in_ctrl_rdy,
  input  wire       in_sob,
  input  wire       in_eob,
  input  wire       batch_id_t in_pbs_id,
  // Towards the first stage
  output block_t    seq_data,
  output logic      seq_avail,
  output logic      seq_sob,
  output logic      seq_eob,
  output batch_id_t seq_pbs_id
);

  logic   accept;
  block_t rev_data;

  // Index width of one block
  function automatic int bit_rev(input int idx);
    int res;
    res = 0;
    for (int i = 0; i < `NTT_S; i++) begin
      res = (res << 1) | ((idx >> i) & 1);
    end
    return res;
  endfunction

  // ----------------------------------------------------------
  // Joint acceptance
  // ----------------------------------------------------------
  // Downstream never stalls, so only the two valids matter
  assign accept      = in_data_vld & in_ctrl_vld;
  assign in_data_rdy = accept;
  assign in_ctrl_rdy = accept;

  // DIT butterflies want the input in bit-reversed order
  always_comb begin
    for (int k = 0; k < `NTT_N; k++) begin
      rev_data[k] = in_data[bit_rev(k)];
    end
  end

  // ----------------------------------------------------------
  // Output register
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      seq_avail <= 1'b0;
    end else begin
      seq_avail <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      seq_data   <= rev_data;
      seq_sob    <= in_sob;
      seq_eob    <= in_eob;
      seq_pbs_id <= in_pbs_id;
    end
  end

endmodule

`default_nettype wire

//--- src/ntt_pp.sv
// Post-process of the forward transform
// Key FIFO on its own valid/ready stream, one entry per data beat
// Point-wise modular multiply of each coefficient by its key factor
// Sticky error when a beat finds the key FIFO empty

`timescale 1ns/1ns
`default_nettype none

`include "ntt_defs.svh"

module ntt_pp
  import ntt_core_pkg::*;
(
  input  wire       clk,
  input  wire       reset,
  input  wire       block_t prev_data,
  input  wire       prev_avail,
  input  wire       prev_sob,
  input  wire       prev_eob,
  input  wire       batch_id_t prev_pbs_id,
  // Key factors
  input  wire       block_t bsk,
  input  wire       bsk_vld,
  output logic      bsk_rdy,
  // Result
  output block_t    next_data,
  output logic      next_avail,
  output logic      next_sob,
  output logic      next_eob,
  output batch_id_t next_pbs_id,
  output logic      ntt_error
);

  localparam int DEPTH = `NTT_PP_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int LAT   = `NTT_MULT_LAT;

  block_t             key_mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               push;
  logic               pop;
  logic               underflow;
  block_t             factor;
  logic [LAT-1:0]     avail_sr;
  logic [LAT-1:0]     sob_sr;
  logic [LAT-1:0]     eob_sr;
  batch_id_t          id_sr [LAT];

  // ----------------------------------------------------------
  // Key FIFO
  // ----------------------------------------------------------
  assign bsk_rdy   = (count < CNT_W'(DEPTH));
  assign push      = bsk_vld & bsk_rdy;
  // A key written in the same cycle is not yet visible
  assign pop       = prev_avail & (count != '0);
  assign underflow = prev_avail & (count == '0);

  // Missing key counts as all-zero factors
  assign factor = underflow ? '0 : key_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      ntt_error <= 1'b0;
      avail_sr  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
      // Sticky until reset
      if (underflow) ntt_error <= 1'b1;
      avail_sr <= {avail_sr[LAT-2:0], prev_avail};
    end
  end

  always_ff @(posedge clk) begin
    if (push) key_mem[wr_ptr] <= bsk;
    sob_sr   <= {sob_sr[LAT-2:0], prev_sob};
    eob_sr   <= {eob_sr[LAT-2:0], prev_eob};
    id_sr[0] <= prev_pbs_id;
    for (int i = 1; i < LAT; i++) begin
      id_sr[i] <= id_sr[i-1];
    end
  end

  // ----------------------------------------------------------
  // Point-wise multiply
  // ----------------------------------------------------------
  for (genvar k = 0; k < `NTT_N; k++) begin : gen_mult
    ntt_mod_mult u_mult (
      .clk   (clk),
      .reset (reset),
      .a     (prev_data[k]),
      .b     (factor[k]),
      .z     (next_data[k])
    );
  end

  assign next_avail  = avail_sr[LAT-1];
  assign next_sob    = sob_sr[LAT-1];
  assign next_eob    = eob_sr[LAT-1];
  assign next_pbs_id = id_sr[LAT-1];

endmodule

`default_nettype wire

//--- src/ntt_middle.sv
// Middle of the NTT head partition
// Chain of the transform stages in DIT order
// Post-process with key multiplication at the end of the chain

`timescale 1ns/1ns
`default_nettype none

`include "ntt_defs.svh"

module ntt_middle
  import ntt_core_pkg::*;
(
  input  wire       clk,
  input  wire       reset,
  input  wire       block_t prev_data,
  input  wire       prev_avail,
  input  wire       prev_sob,
  input  wire       prev_eob,
  input  wire       batch_id_t prev_pbs_id,
  input  wire       twd_pow_t twd_pow,
  input  wire       block_t bsk,
  input  wire       bsk_vld,
  output logic      bsk_rdy,
  output block_t    next_data,
  output logic      next_avail,
  output logic      next_sob,
  output logic      next_eob,
  output batch_id_t next_pbs_id,
  output logic      ntt_error
);

  // Entry s is the input of stage s, the last one feeds the post-process
  block_t     st_data  [`NTT_S+1];
  logic       st_avail [`NTT_S+1];
  logic       st_sob   [`NTT_S+1];
  logic       st_eob   [`NTT_S+1];
  batch_id_t  st_id    [`NTT_S+1];

  assign st_data[0]  = prev_data;
  assign st_avail[0] = prev_avail;
  assign st_sob[0]   = prev_sob;
  assign st_eob[0]   = prev_eob;
  assign st_id[0]    = prev_pbs_id;

  // ----------------------------------------------------------
  // Forward transform, half-span doubles each stage
  // ----------------------------------------------------------
  for (genvar s = 0; s < `NTT_S; s++) begin : gen_stage
    ntt_stage #(
      .STAGE_ID (s)
    ) u_stage (
      .clk         (clk),
      .reset       (reset),
      .prev_data   (st_data[s]),
      .prev_avail  (st_avail[s]),
      .prev_sob    (st_sob[s]),
      .prev_eob    (st_eob[s]),
      .prev_pbs_id (st_id[s]),
      .twd_pow     (twd_pow),
      .next_data   (st_data[s+1]),
      .next_avail  (st_avail[s+1]),
      .next_sob    (st_sob[s+1]),
      .next_eob    (st_eob[s+1]),
      .next_pbs_id (st_id[s+1])
    );
  end

  // ----------------------------------------------------------
  // Key multiplication
  // ----------------------------------------------------------
  ntt_pp u_pp (
    .clk         (clk),
    .reset       (reset),
    .prev_data   (st_data[`NTT_S]),
    .prev_avail  (st_avail[`NTT_S]),
    .prev_sob    (st_sob[`NTT_S]),
    .prev_eob    (st_eob[`NTT_S]),
    .prev_pbs_id (st_id[`NTT_S]),
    .bsk         (bsk),
    .bsk_vld     (bsk_vld),
    .bsk_rdy     (bsk_rdy),
    .next_data   (next_data),
    .next_avail  (next_avail),
    .next_sob    (next_sob),
    .next_eob    (next_eob),
    .next_pbs_id (next_pbs_id),
    .ntt_error   (ntt_error)
  );

endmodule

`default_nettype wire

//--- src/ntt_core_head.sv
// Top level of the NTT head partition
// Input sequencer followed by the stage chain and post-process
// Output avail 12 cycles after an accepted beat

`timescale 1ns/1ns
`default_nettype none

module ntt_core_head
  import ntt_core_pkg::*;
(
  input  wire       clk,
  input  wire       reset,
  // Data and control from the decomposition side
  input  wire       block_t in_data,
  input  wire       in_data_vld,
  output logic      in_data_rdy,
  input  wire       in_ctrl_vld,
  output logic      in_ctrl_rdy,
  input  wire       in_sob,
  input  wire       in_eob,
  input  wire       batch_id_t in_pbs_id,
  // Quasi static omega powers
  input  wire       twd_pow_t twd_pow,
  // Key factors
  input  wire       block_t bsk,
  input  wire       bsk_vld,
  output logic      bsk_rdy,
  // Result, no back-pressure
  output block_t    next_data,
  output logic      next_data_avail,
  output logic      next_sob,
  output logic      next_eob,
  output batch_id_t next_pbs_id,
  output logic      ntt_error
);

  // ----------------------------------------------------------
  // Sequencer to middle
  // ----------------------------------------------------------
  block_t    seq_data;
  logic      seq_avail;
  logic      seq_sob;
  logic      seq_eob;
  batch_id_t seq_pbs_id;

  ntt_seq u_seq (
    .clk         (clk),
    .reset       (reset),
    .in_data     (in_data),
    .in_data_vld (in_data_vld),
    .in_data_rdy (in_data_rdy),
    .in_ctrl_vld (in_ctrl_vld),
    .in_ctrl_rdy (in_ctrl_rdy),
    .in_sob      (in_sob),
    .in_eob      (in_eob),
    .in_pbs_id   (in_pbs_id),
    .seq_data    (seq_data),
    .seq_avail   (seq_avail),
    .seq_sob     (seq_sob),
    .seq_eob     (seq_eob),
    .seq_pbs_id  (seq_pbs_id)
  );

  ntt_middle u_middle (
    .clk         (clk),
    .reset       (reset),
    .prev_data   (seq_data),
    .prev_avail  (seq_avail),
    .prev_sob    (seq_sob),
    .prev_eob    (seq_eob),
    .prev_pbs_id (seq_pbs_id),
    .twd_pow     (twd_pow),
    .bsk         (bsk),
    .bsk_vld     (bsk_vld),
    .bsk_rdy     (bsk_rdy),
    .next_data   (next_data),
    .next_avail  (next_data_avail),
    .next_sob    (next_sob),
    .next_eob    (next_eob),
    .next_pbs_id (next_pbs_id),
    .ntt_error   (ntt_error)
  );

endmodule

`default_nettype wire

//--- testbench/tb_ntt_core_head.sv
// Testbench of the NTT core head partition
// Clock, reset and stimulus on the data, control and key streams
// Reference model with the transform sum formula and key pairing
// Concurrent and immediate assertions on outputs, readies and error

`timescale 1ns/1ns
`default_nettype none

`include "ntt_defs.svh"

module tb_ntt_core_head
  import ntt_core_pkg::*;
();

  localparam int MOD   = `NTT_MOD;
  localparam int DEPTH = `NTT_PP_FIFO_DEPTH;

  logic      clk;
  logic      reset;
  block_t    in_data;
  logic      in_data_vld;
  logic      in_data_rdy;
  logic      in_ctrl_vld;
  logic      in_ctrl_rdy;
  logic      in_sob;
  logic      in_eob;
  batch_id_t in_pbs_id;
  twd_pow_t  twd_pow;
  block_t    bsk;
  logic      bsk_vld;
  logic      bsk_rdy;
  block_t    next_data;
  logic      next_data_avail;
  logic      next_sob;
  logic      next_eob;
  batch_id_t next_pbs_id;
  logic      ntt_error;

  // Expected beats of the model in output order
  block_t    exp_val [$];
  logic      exp_sob [$];
  logic      exp_eob [$];
  batch_id_t exp_id  [$];
  // Edge number at which the output of a beat is sampled
  int        exp_cyc [$];
  block_t    key_q   [$];
  logic      exp_err;
  logic      key_push;
  block_t    key_now;
  int        cyc;
  int        omega;
  int        acc_count;
  int        out_count;
  int        n_checks;
  int        n_errors;
  int        test_err_base;
  int        acc_base;
  int        out_base;
  logic [31:0] rng;

  ntt_core_head dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Arithmetic helpers of the reference model
  // ----------------------------------------------------------
  function automatic int pow_mod(input int base, input int e);
    int r;
    r = 1;
    for (int i = 0; i < e; i++) begin
      r = (r * base) % MOD;
    end
    return r;
  endfunction

  // X[k] = sum of x[n] * omega^(n*k)
  function automatic block_t ref_ntt(input block_t x);
    block_t res;
    int     acc;
    for (int k = 0; k < `NTT_N; k++) begin
      acc = 0;
      for (int n = 0; n < `NTT_N; n++) begin
        acc = (acc + int'(x[n]) * pow_mod(omega, (n * k) % `NTT_N)) % MOD;
      end
      res[k] = coef_t'(acc);
    end
    return res;
  endfunction

  function automatic block_t apply_key(input block_t v, input block_t key);
    block_t res;
    for (int k = 0; k < `NTT_N; k++) begin
      res[k] = coef_t'((int'(v[k]) * int'(key[k])) % MOD);
    end
    return res;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int rand_below(input int limit);
    rng = xorshift32(rng);
    return int'(rng % limit);
  endfunction

  function automatic block_t rand_block();
    block_t b;
    for (int k = 0; k < `NTT_N; k++) begin
      b[k] = coef_t'(rand_below(MOD));
    end
    return b;
  endfunction

  // ----------------------------------------------------------
  // Checking
  // ----------------------------------------------------------
  task automatic expect_true(input logic cond, input string msg);
    n_checks++;
    assert (cond === 1'b1) else begin
      n_errors++;
      $display("Mismatch at %0t: %s", $time, msg);
    end
  endtask

  // Readies follow the joint valid in every cycle
  ready_join_a: assert property (@(posedge clk) disable iff (reset)
      (in_data_rdy == (in_data_vld && in_ctrl_vld)) && (in_ctrl_rdy == in_data_rdy))
    else begin
      n_errors++;
      $display("Mismatch at %0t: readies differ from the joint valid", $time);
    end

  // Error flag is sticky until reset
  error_sticky_a: assert property (@(posedge clk) disable iff (reset)
      ntt_error |=> ntt_error)
    else begin
      n_errors++;
      $display("Mismatch at %0t: ntt_error dropped without reset", $time);
    end

  // Model update at each edge with pops ahead of new keys
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (reset) begin
      exp_val.delete();
      exp_sob.delete();
      exp_eob.delete();
      exp_id.delete();
      exp_cyc.delete();
      key_q.delete();
      exp_err = 1'b0;
    end else begin
      key_push = bsk_vld && (key_q.size() < DEPTH);
      // Beat enters the post-process two edges before its output edge
      for (int i = 0; i < exp_cyc.size(); i++) begin
        if (exp_cyc[i] == cyc + 2) begin
          if (key_q.size() > 0) begin
            key_now = key_q.pop_front();
          end else begin
            key_now = '0;
            exp_err = 1'b1;
          end
          exp_val[i] = apply_key(exp_val[i], key_now);
        end
      end
      if (key_push) begin
        key_q.push_back(bsk);
      end
      if (in_data_vld && in_ctrl_vld) begin
        exp_val.push_back(ref_ntt(in_data));
        exp_sob.push_back(in_sob);
        exp_eob.push_back(in_eob);
        exp_id.push_back(in_pbs_id);
        exp_cyc.push_back(cyc + 12);
      end
      // Handshakes as the DUT completes them
      if (in_data_vld && in_data_rdy && in_ctrl_vld && in_ctrl_rdy) begin
        acc_count++;
      end
    end
  end

  // Outputs compared mid-cycle against the queue head
  always @(negedge clk) begin
    if (!reset) begin
      if (next_data_avail === 1'b1) begin
        out_count++;
      end
      if (exp_cyc.size() > 0 && exp_cyc[0] == cyc + 1) begin
        expect_true(next_data_avail, "next_data_avail missing at its expected time");
        expect_true(next_data === exp_val[0],
          $sformatf("next_data %h, expected %h", next_data, exp_val[0]));
        expect_true(next_sob === exp_sob[0], "next_sob differs");
        expect_true(next_eob === exp_eob[0], "next_eob differs");
        expect_true(next_pbs_id === exp_id[0],
          $sformatf("next_pbs_id %h, expected %h", next_pbs_id, exp_id[0]));
        void'(exp_val.pop_front());
        void'(exp_sob.pop_front());
        void'(exp_eob.pop_front());
        void'(exp_id.pop_front());
        void'(exp_cyc.pop_front());
      end else begin
        expect_true(next_data_avail === 1'b0, "next_data_avail high with no beat due");
      end
      expect_true(ntt_error === exp_err, $sformatf("ntt_error %b, expected %b",
        ntt_error, exp_err));
      expect_true(bsk_rdy === (key_q.size() < DEPTH), "bsk_rdy differs from key count");
      expect_true(in_data_rdy === (in_data_vld && in_ctrl_vld), "in_data_rdy differs");
    end
  end

  // ----------------------------------------------------------
  // Stimulus tasks
  // ----------------------------------------------------------
  task automatic wait_edge();
    @(posedge clk);
    #2;
  endtask

  task automatic report_timeout(input string what);
    n_errors++;
    $display("Timeout at %0t: %s", $time, what);
  endtask

  task automatic do_reset();
    reset = 1'b1;
    repeat (8) wait_edge();
    reset = 1'b0;
  endtask

  task automatic push_key(input block_t key);
    int tries;
    tries = 0;
    bsk     = key;
    bsk_vld = 1'b1;
    while (bsk_rdy !== 1'b1 && tries < 100) begin
      wait_edge();
      tries++;
    end
    if (bsk_rdy !== 1'b1) begin
      report_timeout("key stream never became ready");
    end else begin
      wait_edge();
    end
    bsk_vld = 1'b0;
  endtask

  // Both valids together for one edge
  task automatic send_beat(input block_t data, input logic sob, input logic eob);
    in_data     = data;
    in_sob      = sob;
    in_eob      = eob;
    in_pbs_id   = batch_id_t'(rand_below(16));
    in_data_vld = 1'b1;
    in_ctrl_vld = 1'b1;
    wait_edge();
    in_data_vld = 1'b0;
    in_ctrl_vld = 1'b0;
  endtask

  task automatic wait_drain();
    int tries;
    tries = 0;
    while (exp_cyc.size() != 0 && tries < 100) begin
      wait_edge();
      tries++;
    end
    if (exp_cyc.size() != 0) begin
      report_timeout("expected outputs never appeared");
    end
  endtask

  task automatic end_test(input string name);
    $display("Test %s done, %0d errors", name, n_errors - test_err_base);
    test_err_base = n_errors;
    acc_base      = acc_count;
    out_base      = out_count;
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    block_t blk;
    int     tries;
    reset       = 1'b1;
    in_data     = '0;
    in_data_vld = 1'b0;
    in_ctrl_vld = 1'b0;
    in_sob      = 1'b0;
    in_eob      = 1'b0;
    in_pbs_id   = '0;
    bsk         = '0;
    bsk_vld     = 1'b0;
    exp_err     = 1'b0;
    cyc         = 0;
    acc_count   = 0;
    out_count   = 0;
    n_checks    = 0;
    n_errors    = 0;
    test_err_base = 0;
    rng         = 32'ha0b631be;
    // Primitive 8th root of unity where omega^4 = -1
    omega = 0;
    for (int w = 2; w < MOD; w++) begin
      if (omega == 0 && pow_mod(w, 4) == MOD - 1) begin
        omega = w;
      end
    end
    for (int i = 0; i < `NTT_N / 2; i++) begin
      twd_pow[i] = coef_t'(pow_mod(omega, i));
    end

    do_reset();
    expect_true(next_data_avail === 1'b0, "next_data_avail high after reset");
    expect_true(ntt_error === 1'b0, "ntt_error high after reset");
    expect_true(bsk_rdy === 1'b1, "bsk_rdy low after reset");
    end_test("reset");

    // Impulse, constant, then random blocks, one at a time
    blk    = '0;
    blk[0] = coef_t'(1);
    push_key(rand_block());
    send_beat(blk, 1'b1, 1'b0);
    wait_drain();
    for (int k = 0; k < `NTT_N; k++) begin
      blk[k] = coef_t'(1234);
    end
    push_key(rand_block());
    send_beat(blk, 1'b0, 1'b0);
    wait_drain();
    for (int t = 0; t < 4; t++) begin
      push_key(rand_block());
      send_beat(rand_block(), 1'b0, t == 3);
      wait_drain();
    end
    end_test("single");

    // Keys filled ahead, then one beat per cycle
    repeat (DEPTH) push_key(rand_block());
    fork
      begin
        for (int t = 0; t < 8; t++) begin
          send_beat(rand_block(), t == 0, t == 7);
        end
      end
      begin
        repeat (4) push_key(rand_block());
      end
    join
    wait_drain();
    expect_true(out_count - out_base == 8, "throughput beat count differs");
    end_test("throughput");

    // Valids raised separately with random gaps
    for (int t = 0; t < 6; t++) begin
      push_key(rand_block());
      repeat (rand_below(3)) wait_edge();
      in_data   = rand_block();
      in_sob    = 1'b0;
      in_eob    = 1'b0;
      in_pbs_id = batch_id_t'(t);
      if (rand_below(2) == 0) begin
        in_data_vld = 1'b1;
      end else begin
        in_ctrl_vld = 1'b1;
      end
      repeat (1 + rand_below(3)) wait_edge();
      in_data_vld = 1'b1;
      in_ctrl_vld = 1'b1;
      wait_edge();
      in_data_vld = 1'b0;
      in_ctrl_vld = 1'b0;
    end
    wait_drain();
    expect_true(acc_count - acc_base == 6, "joint acceptance count differs");
    expect_true(out_count - out_base == acc_count - acc_base, "output count differs");
    end_test("joint");

    // Full key FIFO holds the ready low
    repeat (DEPTH) push_key(rand_block());
    expect_true(bsk_rdy === 1'b0, "bsk_rdy high with a full key FIFO");
    send_beat(rand_block(), 1'b1, 1'b0);
    tries = 0;
    while (bsk_rdy !== 1'b1 && tries < 40) begin
      wait_edge();
      tries++;
    end
    if (bsk_rdy !== 1'b1) begin
      report_timeout("bsk_rdy never rose after a key was used");
    end
    // Use up the remaining keys
    repeat (DEPTH - 1) send_beat(rand_block(), 1'b0, 1'b0);
    wait_drain();
    end_test("backpressure");

    // Beat with no key gives zeros and a sticky error
    send_beat(rand_block(), 1'b1, 1'b1);
    wait_drain();
    expect_true(ntt_error === 1'b1, "ntt_error low after key underflow");
    push_key(rand_block());
    send_beat(rand_block(), 1'b0, 1'b0);
    wait_drain();
    expect_true(ntt_error === 1'b1, "ntt_error cleared without reset");
    do_reset();
    expect_true(ntt_error === 1'b0, "ntt_error still high after reset");
    end_test("underflow");

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
src/ntt_core_pkg.sv
src/ntt_mod_mult.sv
src/ntt_bfly.sv
src/ntt_stage.sv
src/ntt_seq.sv
src/ntt_pp.sv
src/ntt_middle.sv
src/ntt_core_head.sv
testbench/tb_ntt_core_head.sv

//--- Bender.yml
package:
  name: ntt_core_head

export_include_dirs:
  - include

sources:
  - src/ntt_core_pkg.sv
  - src/ntt_mod_mult.sv
  - src/ntt_bfly.sv
  - src/ntt_stage.sv
  - src/ntt_seq.sv
  - src/ntt_pp.sv
  - src/ntt_middle.sv
  - src/ntt_core_head.sv
  - target: test
    files:
      - testbench/tb_ntt_core_head.sv
